// File: hdl/bk_bus_decode.sv
// Bus strobe decoder producing one-cycle sysreg and port operation pulses
module bk_bus_decode (
	input  logic                   clk_sys,
	input  logic                   arst_n,
	input  bk_periph_pkg::bus_req_t bus,
	output bk_periph_pkg::bus_op_t  op
);

	logic                  sys_acc;
	logic                  sys_wr;
	logic                  port_wr;
	logic                  sys_acc_q;
	logic                  sys_wr_q;
	logic                  port_wr_q;
	bk_periph_pkg::bus_op_e op_q;
	logic [1:0]            lanes_q;
	logic [15:0]           data_q;

	// Level conditions taken straight from the strobes
	assign sys_acc = bus.stb & bus.sysreg_sel;
	assign sys_wr = sys_acc & bus.we;
	assign port_wr = bus.stb & bus.port_sel & bus.we;

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			sys_acc_q <= 1'b0;
			sys_wr_q <= 1'b0;
			port_wr_q <= 1'b0;
			op_q <= bk_periph_pkg::OP_NONE;
		end else begin
			sys_acc_q <= sys_acc;
			sys_wr_q <= sys_wr;
			port_wr_q <= port_wr;
			// Rising edges only, write ahead of a plain access
			if (sys_wr && !sys_wr_q)
				op_q <= bk_periph_pkg::OP_SYS_WRITE;
			else if (sys_acc && !sys_acc_q)
				op_q <= bk_periph_pkg::OP_SYS_ACCESS;
			else if (port_wr && !port_wr_q)
				op_q <= bk_periph_pkg::OP_PORT_WRITE;
			else
				op_q <= bk_periph_pkg::OP_NONE;
		end
	end

	// Payload follows the bus every cycle
	always_ff @(posedge clk_sys) begin
		lanes_q <= bus.wtbt;
		data_q <= bus.dout;
	end

	assign op = '{op: op_q, lanes: lanes_q, data: data_q};

endmodule

// File: hdl/bk_cpu_clock_enables.sv
// CPU clock-enable divider with BK0010/BK0011M period and turbo halving
module bk_cpu_clock_enables #(
	parameter int DIV_BK0011 = 24,
	parameter int DIV_BK0010 = 32
) (
	input  logic                  clk_sys,
	input  logic                  arst_n,
	input  logic                  bk0010,
	input  logic                  turbo,
	output bk_periph_pkg::cpu_ce_t ce
);

	// Last count and midpoint for each model and speed
	localparam logic [4:0] LAST_11 = 5'(DIV_BK0011 - 1);
	localparam logic [4:0] LAST_11_T = 5'(DIV_BK0011 / 2 - 1);
	localparam logic [4:0] LAST_10 = 5'(DIV_BK0010 - 1);
	localparam logic [4:0] LAST_10_T = 5'(DIV_BK0010 / 2 - 1);
	localparam logic [4:0] MID_11 = 5'(DIV_BK0011 / 2);
	localparam logic [4:0] MID_11_T = 5'(DIV_BK0011 / 4);
	localparam logic [4:0] MID_10 = 5'(DIV_BK0010 / 2);
	localparam logic [4:0] MID_10_T = 5'(DIV_BK0010 / 4);

	logic [4:0] div_cnt;
	logic       model_q;
	logic       turbo_q;
	logic [4:0] last_cnt;
	logic [4:0] mid_cnt;
	logic       ce_p_q;
	logic       ce_n_q;
	logic       ce_bus2_q;

	always_comb begin
		case ({model_q, turbo_q})
			2'b00: begin
				last_cnt = LAST_11;
				mid_cnt = MID_11;
			end
			2'b01: begin
				last_cnt = LAST_11_T;
				mid_cnt = MID_11_T;
			end
			2'b10: begin
				last_cnt = LAST_10;
				mid_cnt = MID_10;
			end
			default: begin
				last_cnt = LAST_10_T;
				mid_cnt = MID_10_T;
			end
		endcase
	end

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			div_cnt <= '0;
			model_q <= 1'b0;
			turbo_q <= 1'b0;
			ce_p_q <= 1'b0;
			ce_n_q <= 1'b0;
			ce_bus2_q <= 1'b0;
		end else begin
			div_cnt <= div_cnt + 5'd1;
			// Model and speed only change on a period boundary
			if (div_cnt == last_cnt) begin
				div_cnt <= '0;
				model_q <= bk0010;
				turbo_q <= turbo;
			end
			ce_p_q <= (div_cnt == 5'd0);
			ce_n_q <= (div_cnt == mid_cnt);
			ce_bus2_q <= ce_p_q;
		end
	end

	assign ce = '{ce_p: ce_p_q, ce_n: ce_n_q, ce_bus2: ce_bus2_q};

endmodule

// File: hdl/bk_periph_pkg.sv
// BK0011M peripheral glue package: bus, config, mouse, clock-enable and operation types
package bk_periph_pkg;

	////////////////////////////////
	// Shared constants
	////////////////////////////////

	// Speaker field {bit6, bit5, bit2}
	parameter int SPK_W = 3;
	parameter int AUDIO_W = 16;

	// Mouse movement needed before a direction bit is raised
	parameter int MOUSE_THRESH_POS = 3;
	parameter int MOUSE_THRESH_NEG = 2;

	////////////////////////////////
	// Bus and configuration
	////////////////////////////////

	// One CPU bus cycle as seen by the peripherals
	typedef struct packed {
		logic        sysreg_sel;
		logic        port_sel;
		logic        stb;
		logic        we;
		logic [1:0]  wtbt;
		logic [15:0] dout;
	} bus_req_t;

	// Static machine settings
	typedef struct packed {
		logic       bk0010;
		logic       turbo;
		logic       covox_enable;
		logic [7:0] start_addr;
		logic       key_down;
	} periph_cfg_t;

	// One mouse report, toggle flips for every new report
	typedef struct packed {
		logic              toggle;
		logic [1:0]        btn;
		logic signed [8:0] dx;
		logic signed [8:0] dy;
	} mouse_pkt_t;

	typedef struct packed {
		logic ce_p;
		logic ce_n;
		logic ce_bus2;
	} cpu_ce_t;

	////////////////////////////////
	// Decoded operations
	////////////////////////////////

	typedef enum logic [1:0] {
		OP_NONE,
		OP_SYS_ACCESS,
		OP_SYS_WRITE,
		OP_PORT_WRITE
	} bus_op_e;

	typedef struct packed {
		bus_op_e     op;
		logic [1:0]  lanes;
		logic [15:0] data;
	} bus_op_t;

endpackage

// File: hdl/bk_periph_top.sv
// BK0011M peripheral glue top: clock enables, bus decode, registers and result path
module bk_periph_top #(
	parameter int DIV_BK0011 = 24,
	parameter int DIV_BK0010 = 32
) (
	input  logic                             clk_sys,
	input  logic                             arst_n,
	input  bk_periph_pkg::bus_req_t           bus,
	input  bk_periph_pkg::periph_cfg_t        cfg,
	input  logic                             key_stop,
	input  logic [15:0]                      joystick,
	input  bk_periph_pkg::mouse_pkt_t         mouse,
	output bk_periph_pkg::cpu_ce_t            ce,
	output logic [15:0]                      rd_data,
	output logic [bk_periph_pkg::AUDIO_W-1:0] audio_l,
	output logic [bk_periph_pkg::AUDIO_W-1:0] audio_r,
	output logic                             stop_irq_mask
);

	bk_periph_pkg::bus_op_t          op;
	logic [bk_periph_pkg::SPK_W-1:0] spk;
	logic                           super_flg;
	logic [15:0]                    covox;
	logic [15:0]                    port_rd;

	bk_cpu_clock_enables #(
		.DIV_BK0011(DIV_BK0011),
		.DIV_BK0010(DIV_BK0010)
	) u_clock_enables (
		.clk_sys(clk_sys),
		.arst_n(arst_n),
		.bk0010(cfg.bk0010),
		.turbo(cfg.turbo),
		.ce(ce)
	);

	bk_bus_decode u_bus_decode (
		.clk_sys(clk_sys),
		.arst_n(arst_n),
		.bus(bus),
		.op(op)
	);

	bk_sysreg_exec u_sysreg_exec (
		.clk_sys(clk_sys),
		.arst_n(arst_n),
		.op(op),
		.bk0010(cfg.bk0010),
		.key_stop(key_stop),
		.spk(spk),
		.super_flg(super_flg),
		.stop_irq_mask(stop_irq_mask)
	);

	bk_port_exec u_port_exec (
		.clk_sys(clk_sys),
		.arst_n(arst_n),
		.op(op),
		.covox_enable(cfg.covox_enable),
		.joystick(joystick),
		.mouse(mouse),
		.covox(covox),
		.port_rd(port_rd)
	);

	bk_read_audio_result u_read_audio_result (
		.clk_sys(clk_sys),
		.arst_n(arst_n),
		.bus(bus),
		.cfg(cfg),
		.spk(spk),
		.super_flg(super_flg),
		.covox(covox),
		.port_rd(port_rd),
		.rd_data(rd_data),
		.audio_l(audio_l),
		.audio_r(audio_r)
	);

endmodule

// File: hdl/bk_port_exec.sv
// Parallel port: covox output latch and mouse/joystick input state
module bk_port_exec (
	input  logic                      clk_sys,
	input  logic                      arst_n,
	input  bk_periph_pkg::bus_op_t     op,
	input  logic                      covox_enable,
	input  logic [15:0]               joystick,
	input  bk_periph_pkg::mouse_pkt_t  mouse,
	output logic [15:0]               covox,
	output logic [15:0]               port_rd
);

	logic       port_wr;
	logic       mouse_wr;
	logic       mouse_new;
	logic       toggle_q;
	logic       mouse_en;
	logic       mouse_src;
	logic [6:0] mouse_state;

	assign port_wr = (op.op == bk_periph_pkg::OP_PORT_WRITE);
	// Without covox the low byte of the port controls the mouse
	assign mouse_wr = port_wr && !covox_enable && op.lanes[0];
	assign mouse_new = (mouse.toggle != toggle_q);

	//////////////////////////////
	// Covox output latch
	//////////////////////////////

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			covox <= '0;
		end else if (port_wr) begin
			if (op.lanes[0])
				covox[7:0] <= op.data[7:0];
			if (op.lanes[1])
				covox[15:8] <= op.data[15:8];
		end
	end

	//////////////////////////////
	// Mouse state
	//////////////////////////////

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			toggle_q <= 1'b0;
			mouse_en <= 1'b0;
			mouse_src <= 1'b0;
			mouse_state <= '0;
		end else begin
			toggle_q <= mouse.toggle;
			if (|joystick)
				mouse_src <= 1'b0;

			if (mouse_wr) begin
				mouse_en <= op.data[3];
				if (!op.data[3])
					mouse_state[3:0] <= '0;
			end

			if (mouse_new) begin
				mouse_state[6] <= mouse.btn[1];
				mouse_state[5] <= mouse.btn[0];
				mouse_src <= 1'b1;
				if (mouse_en) begin
					// Vertical axis, bit 0 up and bit 2 down
					if (!mouse_state[0] && !mouse_state[2]) begin
						if ($signed(mouse.dy) > bk_periph_pkg::MOUSE_THRESH_POS)
							mouse_state[0] <= 1'b1;
						if ($signed(mouse.dy) <= -(bk_periph_pkg::MOUSE_THRESH_NEG + 1))
							mouse_state[2] <= 1'b1;
					end
					// Horizontal axis on bits 1 and 3
					if (!mouse_state[1] && !mouse_state[3]) begin
						if ($signed(mouse.dx) > bk_periph_pkg::MOUSE_THRESH_POS)
							mouse_state[1] <= 1'b1;
						if ($signed(mouse.dx) <= -(bk_periph_pkg::MOUSE_THRESH_NEG + 1))
							mouse_state[3] <= 1'b1;
					end
				end
			end
		end
	end

	assign port_rd = (!covox_enable && mouse_src) ? {9'd0, mouse_state} : joystick;

endmodule

// File: hdl/bk_read_audio_result.sv
// Registered CPU read-data mux and speaker/covox audio mix
module bk_read_audio_result (
	input  logic                             clk_sys,
	input  logic                             arst_n,
	input  bk_periph_pkg::bus_req_t           bus,
	input  bk_periph_pkg::periph_cfg_t        cfg,
	input  logic [bk_periph_pkg::SPK_W-1:0]   spk,
	input  logic                             super_flg,
	input  logic [15:0]                      covox,
	input  logic [15:0]                      port_rd,
	output logic [15:0]                      rd_data,
	output logic [bk_periph_pkg::AUDIO_W-1:0] audio_l,
	output logic [bk_periph_pkg::AUDIO_W-1:0] audio_r
);

	localparam int CH_W = 10;

	logic [15:0]     sys_word;
	logic [CH_W-1:0] ch_l;
	logic [CH_W-1:0] ch_r;
	logic [CH_W-1:0] ch_l_q;
	logic [CH_W-1:0] ch_r_q;

	assign sys_word = {cfg.start_addr, 1'b1, ~cfg.key_down, 3'b000, super_flg, 2'b00};

	// Covox halves the speaker level to leave room for the sample
	assign ch_l = cfg.covox_enable ?
		{1'b0, spk, 6'd0} + {1'b0, covox[7:0], 1'b0} : {spk, 7'd0};
	assign ch_r = cfg.covox_enable ?
		{1'b0, spk, 6'd0} + {1'b0, covox[15:8], 1'b0} : {spk, 7'd0};

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			rd_data <= '0;
			ch_l_q <= '0;
			ch_r_q <= '0;
		end else begin
			if (bus.sysreg_sel)
				rd_data <= sys_word;
			else if (bus.port_sel)
				rd_data <= port_rd;
			else
				rd_data <= '0;
			ch_l_q <= ch_l;
			ch_r_q <= ch_r;
		end
	end

	assign audio_l = {ch_l_q, {(bk_periph_pkg::AUDIO_W - CH_W){1'b0}}};
	assign audio_r = {ch_r_q, {(bk_periph_pkg::AUDIO_W - CH_W){1'b0}}};

endmodule

// File: hdl/bk_sysreg_exec.sv
// System register: speaker bits, STOP interrupt mask and supervisor flag
module bk_sysreg_exec (
	input  logic                           clk_sys,
	input  logic                           arst_n,
	input  bk_periph_pkg::bus_op_t          op,
	input  logic                           bk0010,
	input  logic                           key_stop,
	output logic [bk_periph_pkg::SPK_W-1:0] spk,
	output logic                           super_flg,
	output logic                           stop_irq_mask
);

	logic is_write;
	logic spk_wr;
	logic mask_wr;
	logic stop_mask;
	logic stop_hold;

	assign is_write = (op.op == bk_periph_pkg::OP_SYS_WRITE);

	// Low byte carries the speaker, high byte with bit 11 clear carries the mask
	assign spk_wr = is_write && op.lanes[0] && (!op.lanes[1] || !op.data[11]);
	assign mask_wr = is_write && op.lanes[1] && !op.data[11];

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			spk <= '0;
			super_flg <= 1'b0;
		end else begin
			case (op.op)
				bk_periph_pkg::OP_SYS_ACCESS: super_flg <= 1'b0;
				bk_periph_pkg::OP_SYS_WRITE: super_flg <= 1'b1;
				default: super_flg <= super_flg;
			endcase
			// BK0010 has no third speaker bit
			if (spk_wr)
				spk <= {op.data[6], op.data[5], op.data[2] & ~bk0010};
		end
	end

	//////////////////////////////
	// STOP key interrupt mask
	//////////////////////////////

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			stop_mask <= 1'b0;
			stop_hold <= 1'b0;
		end else begin
			if (mask_wr)
				stop_mask <= op.data[12];
			// Unmasking with STOP still held keeps the block until release
			stop_hold <= key_stop &
				(stop_hold | (mask_wr & ~op.data[12] & stop_mask));
		end
	end

	assign stop_irq_mask = stop_mask | stop_hold;

endmodule

// File: project.f
hdl/bk_periph_pkg.sv
hdl/bk_cpu_clock_enables.sv
hdl/bk_bus_decode.sv
hdl/bk_sysreg_exec.sv
hdl/bk_port_exec.sv
hdl/bk_read_audio_result.sv
hdl/bk_periph_top.sv
tb/bk_periph_asserts.sv
tb/bk_periph_checker.sv
tb/tb_bk_periph.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the peripheral glue testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
	--top-module tb_bk_periph -f project.f -o sim_bk_periph

# Keep running past assertion errors so the testbench can print its verdict
sim_out=$(./obj_dir/sim_bk_periph +verilator+error+limit+1000) || true
echo "$sim_out"

if grep -q "^PASS: all tests$" <<< "$sim_out"; then
	exit 0
else
	exit 1
fi

// File: tb/bk_periph_asserts.sv
// Concurrent checks on the CPU clock enables and the decoded operation pulses
module bk_periph_asserts (
	input logic                   clk_sys,
	input logic                   arst_n,
	input bk_periph_pkg::cpu_ce_t ce,
	input bk_periph_pkg::bus_op_t op
);
	timeunit 1ns;
	timeprecision 100ps;

	int fail_cnt = 0;

	// Rising and falling phase enables are never in the same cycle
	ce_exclusive: assert property (@(posedge clk_sys) disable iff (!arst_n)
		!(ce.ce_p && ce.ce_n))
		else begin
			fail_cnt++;
			$error("ce_p and ce_n pulsed in the same cycle");
		end

	// A held strobe still gives a single one-cycle operation
	op_single: assert property (@(posedge clk_sys) disable iff (!arst_n)
		(op.op != bk_periph_pkg::OP_NONE) |=> (op.op == bk_periph_pkg::OP_NONE))
		else begin
			fail_cnt++;
			$error("operation pulse lasted two cycles");
		end

	reset_quiet: assert property (@(posedge clk_sys) !arst_n |-> (ce == '0))
		else begin
			fail_cnt++;
			$error("clock enables active during reset");
		end

endmodule

bind bk_periph_top bk_periph_asserts u_asserts (
	.clk_sys(clk_sys),
	.arst_n(arst_n),
	.ce(ce),
	.op(op)
);

// File: tb/bk_periph_checker.sv
// Result checker: measures the clock enables and compares DUT outputs with expected values
module bk_periph_checker (
	input  logic                              clk_sys,
	input  logic                              arst_n,
	input  bk_periph_pkg::periph_cfg_t        cfg,
	input  bk_periph_pkg::cpu_ce_t            ce,
	input  logic [15:0]                       rd_data,
	input  logic [bk_periph_pkg::AUDIO_W-1:0] audio_l,
	input  logic [bk_periph_pkg::AUDIO_W-1:0] audio_r,
	input  logic                              stop_irq_mask,
	input  logic                              chk_valid,
	input  logic [3:0]                        chk_kind,
	input  logic [2:0][15:0]                  chk_exp,
	input  int                                chk_step,
	output int                                test_cnt,
	output int                                err_cnt
);
	timeunit 1ns;
	timeprecision 100ps;

	int   tests = 0;
	int   errs = 0;
	int   since_p;
	int   p_gap;
	int   n_off;
	logic bus2_exp;

	assign test_cnt = tests;
	assign err_cnt = errs;

	// BK0011M divides by 24, BK0010 by 32, turbo halves either
	function automatic int expected_gap(input logic bk0010, input logic turbo);
		int base;
		base = bk0010 ? 32 : 24;
		return turbo ? base / 2 : base;
	endfunction

	task automatic compare_value(input string what, input logic [15:0] got,
		input logic [15:0] exp);
		if (got !== exp) begin
			errs++;
			$display("[FAIL] %0t: step %0d %s = %h, expected %h",
				$time, chk_step, what, got, exp);
		end
	endtask

	task automatic run_check();
		int errs_before;
		string kind_name;
		errs_before = errs;
		case (chk_kind)
			4'd1: begin
				kind_name = "cfg";
				compare_value("ce_p spacing", 16'(p_gap), chk_exp[0]);
				compare_value("twice ce_n offset", 16'(n_off * 2), 16'(p_gap));
				compare_value("spacing in stimulus file", chk_exp[0],
					16'(expected_gap(cfg.bk0010, cfg.turbo)));
			end
			4'd2: begin
				kind_name = "write";
				compare_value("audio_l", audio_l, chk_exp[0]);
				compare_value("audio_r", audio_r, chk_exp[1]);
				compare_value("stop_irq_mask", {15'd0, stop_irq_mask}, chk_exp[2]);
			end
			4'd3: begin
				kind_name = "read";
				compare_value("rd_data", rd_data, chk_exp[0]);
			end
			default: begin
				kind_name = "unknown";
				errs++;
				$display("Checker got a request of unknown kind %0d at step %0d",
					chk_kind, chk_step);
			end
		endcase
		tests++;
		if (errs == errs_before)
			$display("step %0d %s: ok", chk_step, kind_name);
		else
			$display("step %0d %s: mismatch", chk_step, kind_name);
	endtask

	//////////////////////////////
	// Sampling away from the active edge
	//////////////////////////////

	always @(negedge clk_sys) begin
		if (!arst_n) begin
			since_p = 0;
			p_gap = 0;
			n_off = 0;
			bus2_exp = 1'b0;
		end else begin
			// Bus enable trails the rising phase enable by one cycle
			if (ce.ce_bus2 !== bus2_exp) begin
				errs++;
				$display("[FAIL] %0t: ce_bus2 = %b, expected %b one cycle after ce_p",
					$time, ce.ce_bus2, bus2_exp);
			end
			bus2_exp = ce.ce_p;
			if (ce.ce_n)
				n_off = since_p;
			if (ce.ce_p) begin
				p_gap = since_p;
				since_p = 1;
			end else begin
				since_p++;
			end
			if (chk_valid)
				run_check();
		end
	end

endmodule

// File: tb/bk_periph_stim.txt
// op a b c e0 e1 e2 in hex; 1 cfg (a = cfg bits, e0 = ce_p spacing), 3 read (a = sel, e0 = rd_data)
// 2 write (a = sel 1 sys 2 port, b = lanes, c = data, e0/e1 = audio l/r, e2 = stop mask), 4 mouse, 5 joy
1 0100 0 0000 0018 0000 0
1 0500 0 0000 000c 0000 0
1 0900 0 0000 0020 0000 0
1 0d00 0 0000 0010 0000 0
1 0101 0 0000 0018 0000 0
2 1 1 0064 e000 e000 0
2 1 1 0020 4000 4000 0
2 1 2 1000 4000 4000 1
2 1 3 0840 4000 4000 1
3 1 0 0000 8084 0000 0
3 1 0 0000 8080 0000 0
2 1 3 0004 2000 2000 0
3 0 0 0000 0000 0000 0
1 0301 0 0000 0018 0000 0
2 2 1 0050 3800 1000 0
2 2 2 c300 3800 7180 0
2 2 3 ffff 8f80 8f80 0
1 0101 0 0000 0018 0000 0
2 2 1 0008 2000 2000 0
4 0 0003 01fd 0000 0000 0
4 2 0004 0005 0000 0000 0
3 2 0 0000 0046 0000 0
2 2 1 0000 2000 2000 0
4 1 000a 01f6 0000 0000 0
3 2 0 0000 0020 0000 0
2 2 1 0008 2000 2000 0
4 3 01fe 0003 0000 0000 0
3 2 0 0000 0060 0000 0
5 0011 0 0000 0000 0000 0
3 2 0 0000 0011 0000 0
f 0 0 0000 0000 0000 0

// File: tb/tb_bk_periph.sv
// Testbench top for the BK0011M peripheral glue, stepping through a stimulus file
module tb_bk_periph;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int COLS = 7;
	localparam int MAX_STEPS = 64;
	localparam int RESET_CYCLES = 16;
	localparam int STEP_BUDGET = 64;

	logic                              clk_sys;
	logic                              arst_n;
	bk_periph_pkg::bus_req_t           bus;
	bk_periph_pkg::periph_cfg_t        cfg;
	logic                              key_stop;
	logic [15:0]                       joystick;
	bk_periph_pkg::mouse_pkt_t         mouse;
	bk_periph_pkg::cpu_ce_t            ce;
	logic [15:0]                       rd_data;
	logic [bk_periph_pkg::AUDIO_W-1:0] audio_l;
	logic [bk_periph_pkg::AUDIO_W-1:0] audio_r;
	logic                              stop_irq_mask;

	logic             chk_valid;
	logic [3:0]       chk_kind;
	logic [2:0][15:0] chk_exp;
	int               chk_step;
	int               test_cnt;
	int               err_cnt;

	logic [15:0] stim [MAX_STEPS*COLS];
	int          n_steps = 0;

	initial clk_sys = 1'b0;
	always #4 clk_sys = ~clk_sys;

	bk_periph_top dut (
		.clk_sys(clk_sys),
		.arst_n(arst_n),
		.bus(bus),
		.cfg(cfg),
		.key_stop(key_stop),
		.joystick(joystick),
		.mouse(mouse),
		.ce(ce),
		.rd_data(rd_data),
		.audio_l(audio_l),
		.audio_r(audio_r),
		.stop_irq_mask(stop_irq_mask)
	);

	bk_periph_checker u_checker (
		.clk_sys(clk_sys),
		.arst_n(arst_n),
		.cfg(cfg),
		.ce(ce),
		.rd_data(rd_data),
		.audio_l(audio_l),
		.audio_r(audio_r),
		.stop_irq_mask(stop_irq_mask),
		.chk_valid(chk_valid),
		.chk_kind(chk_kind),
		.chk_exp(chk_exp),
		.chk_step(chk_step),
		.test_cnt(test_cnt),
		.err_cnt(err_cnt)
	);

	//////////////////////////////
	// Stimulus helpers
	//////////////////////////////

	task automatic next_cycle();
		@(posedge clk_sys);
		#1;
	endtask

	task automatic idle_gap();
		int unsigned gap;
		gap = $urandom % 4;
		repeat (gap) next_cycle();
	endtask

	// Steps end at an f marker, anything outside 1..5 before it is a broken file
	function automatic int count_steps();
		int n;
		n = 0;
		while (n < MAX_STEPS) begin
			if (stim[n*COLS] == 16'hf)
				return n;
			if (stim[n*COLS] == 16'd0 || stim[n*COLS] > 16'd5)
				return -1;
			n++;
		end
		return -1;
	endfunction

	task automatic request_check(input int step, input logic [3:0] kind,
		input logic [15:0] e0, input logic [15:0] e1, input logic [15:0] e2);
		chk_step = step;
		chk_kind = kind;
		chk_exp[0] = e0;
		chk_exp[1] = e1;
		chk_exp[2] = e2;
		chk_valid = 1'b1;
		next_cycle();
		chk_valid = 1'b0;
	endtask

	task automatic wait_ce_pulses(input int n);
		int seen;
		seen = 0;
		while (seen < n) begin
			@(negedge clk_sys);
			if (ce.ce_p)
				seen++;
		end
		next_cycle();
	endtask

	task automatic apply_cfg(input int step, input logic [15:0] val, input logic [15:0] gap);
		cfg = val[11:0];
		// First pulse may close the old period, the third ends a clean new one
		wait_ce_pulses(3);
		request_check(step, 4'd1, gap, 16'd0, 16'd0);
	endtask

	task automatic bus_write(input logic [15:0] sel, input logic [15:0] lanes,
		input logic [15:0] data);
		bus.sysreg_sel = (sel == 16'd1);
		bus.port_sel = (sel == 16'd2);
		bus.stb = 1'b1;
		bus.we = 1'b1;
		bus.wtbt = lanes[1:0];
		bus.dout = data;
		// Strobe held over two edges
		next_cycle();
		next_cycle();
		bus = '0;
		next_cycle();
	endtask

	task automatic bus_read(input int step, input logic [15:0] sel, input logic [15:0] exp);
		bus.sysreg_sel = (sel == 16'd1);
		bus.port_sel = (sel == 16'd2);
		bus.stb = 1'b1;
		bus.we = 1'b0;
		bus.wtbt = 2'b11;
		bus.dout = '0;
		next_cycle();
		request_check(step, 4'd3, exp, 16'd0, 16'd0);
		bus = '0;
	endtask

	task automatic send_mouse(input logic [15:0] btn, input logic [15:0] dx,
		input logic [15:0] dy);
		mouse.btn = btn[1:0];
		mouse.dx = dx[8:0];
		mouse.dy = dy[8:0];
		mouse.toggle = ~mouse.toggle;
		next_cycle();
	endtask

	//////////////////////////////
	// Main sequence
	//////////////////////////////

	initial begin
		int i;
		int step;
		int base;
		int assert_fails;
		void'($urandom(32'hcfcb_5bb0));
		arst_n = 1'b0;
		bus = '0;
		cfg = '0;
		key_stop = 1'b0;
		joystick = '0;
		mouse = '0;
		chk_valid = 1'b0;
		chk_kind = '0;
		chk_exp = '0;
		chk_step = 0;
		for (i = 0; i < MAX_STEPS * COLS; i++)
			stim[i] = '0;
		$readmemh("tb/bk_periph_stim.txt", stim);
		repeat (RESET_CYCLES) @(posedge clk_sys);
		#1;
		arst_n = 1'b1;
		n_steps = count_steps();
		if (n_steps <= 0) begin
			$display("Stimulus file is missing, malformed or has no end marker");
			$display("FAIL: see errors above");
			$finish;
		end else begin
			for (step = 0; step < n_steps; step++) begin
				base = step * COLS;
				case (stim[base])
					16'd1: apply_cfg(step, stim[base+1], stim[base+4]);
					16'd2: begin
						bus_write(stim[base+1], stim[base+2], stim[base+3]);
						request_check(step, 4'd2, stim[base+4], stim[base+5],
							stim[base+6]);
					end
					16'd3: bus_read(step, stim[base+1], stim[base+4]);
					16'd4: send_mouse(stim[base+1], stim[base+2], stim[base+3]);
					// Joystick level
					default: begin
						joystick = stim[base+1];
						next_cycle();
					end
				endcase
				idle_gap();
			end
			repeat (2) next_cycle();
			assert_fails = dut.u_asserts.fail_cnt;
			$display("Summary: %0d tests, %0d failed checks, %0d assertion failures",
				test_cnt, err_cnt, assert_fails);
			if (test_cnt > 0 && err_cnt == 0 && assert_fails == 0)
				$display("PASS: all tests");
			else
				$display("FAIL: see errors above");
			$finish;
		end
	end

	initial begin : watchdog
		wait (n_steps > 0);
		repeat (RESET_CYCLES + n_steps * STEP_BUDGET) @(posedge clk_sys);
		$display("Timeout: %0d steps did not finish within %0d cycles",
			n_steps, n_steps * STEP_BUDGET);
		$display("FAIL: see errors above");
		$finish;
	end

endmodule
